// File: common/issue_defines.svh
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// Register assignment delay, empty for synthesis
`define SD

`define TAG_W    5                // Physical tag width
`define NUM_TAGS (1 << `TAG_W)    // Tags in the ready table
`define NUM_FU   4                // Units, one reservation entry each

`define ALU_LAT  1                // ALU pipeline depth
`define MUL_LAT  3                // MUL pipeline depth

// Unit class per index, entry 0 first
`define FU_LIST '{fu_pkg::FU_ALU, fu_pkg::FU_ALU, fu_pkg::FU_MUL, fu_pkg::FU_MUL}

`define ZERO_TAG    '0            // Always-ready zero register
`define READY_RESET '1            // Every tag ready out of reset
`define PIPE_RESET  '0            // Empty pipe stage
`define PTR_RESET   '0            // Arbiter starts at unit 0

`endif

// File: common/tag_pkg.sv
`include "issue_defines.svh"

package tag_pkg;

  // Physical register tag, 0 is the zero register
  typedef logic [`TAG_W-1:0] tag_t;

  // One bit per physical tag
  typedef logic [`NUM_TAGS-1:0] tag_mask_t;

  // One tag per unit or per reservation entry
  typedef tag_t [`NUM_FU-1:0] tag_vec_t;

endpackage

// File: common/fu_pkg.sv
`include "issue_defines.svh"

package fu_pkg;

  // Functional unit class
  typedef enum logic [0:0] {
    FU_ALU = 1'b0,
    FU_MUL = 1'b1
  } fu_t;

  typedef logic [`NUM_FU-1:0]         fu_mask_t;   // One bit per unit
  typedef logic [$clog2(`NUM_FU)-1:0] fu_idx_t;    // Unit index
  typedef fu_t                        fu_table_t [`NUM_FU]; // Class per unit index

  // Pipe stage as {valid, tag}
  typedef logic [`TAG_W:0] pipe_stage_t;

  // Pipeline depth of a class
  function automatic int fu_latency(fu_t fu);
    return (fu == FU_MUL) ? `MUL_LAT : `ALU_LAT;
  endfunction

endpackage

// File: hw/ready_table.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module ready_table (
  input  logic          clock,
  input  logic          reset,
  input  logic          en,
  input  tag_pkg::tag_t src1_tag,
  input  tag_pkg::tag_t src2_tag,
  input  logic          dispatch_fire,
  input  tag_pkg::tag_t dest_tag,
  input  logic          cdb_valid,
  input  tag_pkg::tag_t cdb_tag,
  output logic          src1_ready,
  output logic          src2_ready
);

  tag_pkg::tag_mask_t ready_q; // Tag holds a valid value
  tag_pkg::tag_mask_t ready_d;

  // Dispatch lookup
  always_comb begin
    src1_ready = ready_q[src1_tag]
              || (cdb_valid && cdb_tag == src1_tag) // Completing this cycle
              || src1_tag == `ZERO_TAG;             // Zero register
    src2_ready = ready_q[src2_tag]
              || (cdb_valid && cdb_tag == src2_tag)
              || src2_tag == `ZERO_TAG;
  end

  // CDB sets, dispatch clears the new destination
  always_comb begin
    ready_d = ready_q;
    if (cdb_valid) begin
      ready_d[cdb_tag] = 1'b1;
    end
    if (dispatch_fire) begin
      ready_d[dest_tag] = 1'b0; // Value now pending
    end
    ready_d[`ZERO_TAG] = 1'b1; // Never pending
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= `SD `READY_RESET;
    end else if (en) begin
      ready_q <= `SD ready_d;
    end
  end

endmodule

// File: hw/rs/rs.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module rs (
  input  logic              clock,
  input  logic              reset,
  input  logic              en,
  input  logic              dispatch_en,
  input  fu_pkg::fu_t       dispatch_fu,
  input  tag_pkg::tag_t     dest_tag,
  input  tag_pkg::tag_t     src1_tag,
  input  tag_pkg::tag_t     src2_tag,
  input  logic              src1_ready,
  input  logic              src2_ready,
  input  logic              cdb_valid,
  input  tag_pkg::tag_t     cdb_tag,
  input  fu_pkg::fu_mask_t  accept_mask,
  output logic              dispatch_ready,
  output logic              dispatch_fire,
  output fu_pkg::fu_mask_t  issue_mask,
  output tag_pkg::tag_vec_t issue_tag
);

  localparam fu_pkg::fu_table_t FU_TABLE = `FU_LIST; // Entry i feeds unit i

  fu_pkg::fu_mask_t  busy_q, busy_d;       // Entry holds an instruction
  tag_pkg::tag_vec_t dest_q, dest_d;       // Destination tag per entry
  tag_pkg::tag_vec_t s1_tag_q, s1_tag_d;   // Source 1 tag
  tag_pkg::tag_vec_t s2_tag_q, s2_tag_d;   // Source 2 tag
  fu_pkg::fu_mask_t  s1_rdy_q, s1_rdy_d;   // Source 1 value available
  fu_pkg::fu_mask_t  s2_rdy_q, s2_rdy_d;   // Source 2 value available
  fu_pkg::fu_mask_t  s1_wake;              // Stored or woken this cycle
  fu_pkg::fu_mask_t  s2_wake;
  fu_pkg::fu_mask_t  entry_free;           // Empty or leaving now
  fu_pkg::fu_mask_t  dispatch_sel;         // Entry picked for dispatch

  // Wakeup and issue
  always_comb begin
    for (int i = 0; i < `NUM_FU; i++) begin
      s1_wake[i]    = s1_rdy_q[i] || (cdb_valid && s1_tag_q[i] == cdb_tag); // CDB bypass
      s2_wake[i]    = s2_rdy_q[i] || (cdb_valid && s2_tag_q[i] == cdb_tag);
      issue_mask[i] = busy_q[i] && s1_wake[i] && s2_wake[i] && accept_mask[i];
      entry_free[i] = !busy_q[i] || issue_mask[i]; // Issuing entry can be refilled
    end
  end

  assign issue_tag = dest_q; // Unit carries the destination tag

  // Hazard check, lowest free entry of the class wins
  always_comb begin
    dispatch_sel   = '0;
    dispatch_ready = 1'b0;
    for (int i = 0; i < `NUM_FU; i++) begin
      if (!dispatch_ready && entry_free[i] && FU_TABLE[i] == dispatch_fu) begin
        dispatch_sel[i] = 1'b1;
        dispatch_ready  = 1'b1; // No structural hazard
      end
    end
  end

  assign dispatch_fire = en && dispatch_en && dispatch_ready; // Accepted dispatch

  // Entry update
  always_comb begin
    busy_d   = busy_q;
    dest_d   = dest_q;
    s1_tag_d = s1_tag_q;
    s2_tag_d = s2_tag_q;
    s1_rdy_d = s1_wake;  // Keep what the CDB woke
    s2_rdy_d = s2_wake;
    for (int i = 0; i < `NUM_FU; i++) begin
      if (issue_mask[i]) begin
        busy_d[i] = 1'b0; // Leaves for the unit
      end
      if (dispatch_fire && dispatch_sel[i]) begin
        busy_d[i]   = 1'b1;
        dest_d[i]   = dest_tag;
        s1_tag_d[i] = src1_tag;
        s2_tag_d[i] = src2_tag;
        s1_rdy_d[i] = src1_ready; // Ready table already bypasses the CDB
        s2_rdy_d[i] = src2_ready;
      end
    end
  end

  // Control state
  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q   <= `SD '0;
      s1_rdy_q <= `SD '0;
      s2_rdy_q <= `SD '0;
    end else if (en) begin
      busy_q   <= `SD busy_d;
      s1_rdy_q <= `SD s1_rdy_d;
      s2_rdy_q <= `SD s2_rdy_d;
    end
  end

  // Tag payload
  always_ff @(posedge clock) begin
    if (en) begin
      dest_q   <= `SD dest_d;
      s1_tag_q <= `SD s1_tag_d;
      s2_tag_q <= `SD s2_tag_d;
    end
  end

endmodule

// File: hw/fu/fu_bank.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module fu_bank (
  input  logic              clock,
  input  logic              reset,
  input  logic              en,
  input  fu_pkg::fu_mask_t  issue_mask,
  input  tag_pkg::tag_vec_t issue_tag,
  input  fu_pkg::fu_mask_t  grant_mask,
  output fu_pkg::fu_mask_t  accept_mask,
  output fu_pkg::fu_mask_t  done_mask,
  output tag_pkg::tag_vec_t done_tag
);

  localparam fu_pkg::fu_table_t FU_TABLE = `FU_LIST;

  for (genvar u = 0; u < `NUM_FU; u++) begin : g_unit
    localparam int LAT = fu_pkg::fu_latency(FU_TABLE[u]); // Depth from class

    fu_pkg::pipe_stage_t stage_q [LAT]; // Stage 0 takes the issue
    fu_pkg::pipe_stage_t stage_d [LAT];
    logic [LAT-1:0]      can_take;      // Stage may load from behind

    // Back-pressure, last stage moves only on grant
    always_comb begin
      can_take[LAT-1] = !stage_q[LAT-1][`TAG_W] || grant_mask[u];
      for (int k = LAT - 2; k >= 0; k--) begin
        can_take[k] = !stage_q[k][`TAG_W] || can_take[k+1]; // Fill bubbles ahead
      end
    end

    // Shift where allowed, hold otherwise
    always_comb begin
      stage_d[0] = can_take[0] ? {issue_mask[u], issue_tag[u]} : stage_q[0];
      for (int k = 1; k < LAT; k++) begin
        stage_d[k] = can_take[k] ? stage_q[k-1] : stage_q[k];
      end
    end

    always_ff @(posedge clock) begin
      if (reset) begin
        for (int k = 0; k < LAT; k++) begin
          stage_q[k] <= `SD `PIPE_RESET;
        end
      end else if (en) begin
        stage_q <= `SD stage_d;
      end
    end

    assign accept_mask[u] = can_take[0];                       // Room for a new issue
    assign done_mask[u]   = stage_q[LAT-1][`TAG_W];            // Result waiting for CDB
    assign done_tag[u]    = stage_q[LAT-1][`TAG_W-1:0];
  end

endmodule

// File: hw/cdb_arbiter.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module cdb_arbiter (
  input  logic              clock,
  input  logic              reset,
  input  logic              en,
  input  fu_pkg::fu_mask_t  done_mask,
  input  tag_pkg::tag_vec_t done_tag,
  output fu_pkg::fu_mask_t  grant_mask,
  output logic              cdb_valid,
  output tag_pkg::tag_t     cdb_tag
);

  fu_pkg::fu_idx_t ptr_q;  // Highest priority unit
  fu_pkg::fu_idx_t ptr_d;
  fu_pkg::fu_idx_t cand;   // Unit being checked
  fu_pkg::fu_idx_t winner; // Granted unit

  // First requester at or after the pointer
  always_comb begin
    grant_mask = '0;
    cdb_valid  = 1'b0;
    cdb_tag    = `ZERO_TAG;
    winner     = ptr_q;
    cand       = ptr_q;
    for (int j = 0; j < `NUM_FU; j++) begin
      cand = fu_pkg::fu_idx_t'((int'(ptr_q) + j) % `NUM_FU); // Wrap around
      if (!cdb_valid && done_mask[cand]) begin
        grant_mask[cand] = 1'b1;
        cdb_valid        = 1'b1;
        cdb_tag          = done_tag[cand]; // Same-cycle broadcast
        winner           = cand;
      end
    end
    // Move past the winner
    ptr_d = cdb_valid ? fu_pkg::fu_idx_t'((int'(winner) + 1) % `NUM_FU) : ptr_q;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ptr_q <= `SD `PTR_RESET;
    end else if (en) begin
      ptr_q <= `SD ptr_d;
    end
  end

endmodule

// File: hw/issue_core.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_core (
  input  logic          clock,
  input  logic          reset,
  input  logic          en,
  input  logic          dispatch_en,
  input  fu_pkg::fu_t   dispatch_fu,
  input  tag_pkg::tag_t dest_tag,
  input  tag_pkg::tag_t src1_tag,
  input  tag_pkg::tag_t src2_tag,
  output logic          dispatch_ready,
  output logic          cdb_valid,
  output tag_pkg::tag_t cdb_tag
);

  logic              src1_ready;    // Lookup at dispatch
  logic              src2_ready;
  logic              dispatch_fire; // Accepted dispatch
  fu_pkg::fu_mask_t  issue_mask;    // RS to units
  tag_pkg::tag_vec_t issue_tag;
  fu_pkg::fu_mask_t  accept_mask;   // Units able to take an issue
  fu_pkg::fu_mask_t  done_mask;     // Units with a finished tag
  tag_pkg::tag_vec_t done_tag;
  fu_pkg::fu_mask_t  grant_mask;    // CDB winner

  ready_table i_ready_table (
    .clock, .reset, .en,
    .src1_tag, .src2_tag,
    .dispatch_fire, .dest_tag,
    .cdb_valid, .cdb_tag,
    .src1_ready, .src2_ready
  );

  rs i_rs (
    .clock, .reset, .en,
    .dispatch_en, .dispatch_fu,
    .dest_tag, .src1_tag, .src2_tag,
    .src1_ready, .src2_ready,
    .cdb_valid, .cdb_tag,
    .accept_mask,
    .dispatch_ready, .dispatch_fire,
    .issue_mask, .issue_tag
  );

  fu_bank i_fu_bank (
    .clock, .reset, .en,
    .issue_mask, .issue_tag,
    .grant_mask,
    .accept_mask, .done_mask, .done_tag
  );

  cdb_arbiter i_cdb_arbiter (
    .clock, .reset, .en,
    .done_mask, .done_tag,
    .grant_mask, .cdb_valid, .cdb_tag
  );

endmodule

// File: dv/issue_core_asserts.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_core_asserts (
  input logic          clock,
  input logic          reset,
  input logic          en,
  input logic          dispatch_fire,
  input tag_pkg::tag_t dest_tag,
  input logic          dispatch_ready,
  input logic          cdb_valid,
  input tag_pkg::tag_t cdb_tag
);

  tag_pkg::tag_mask_t sent_q;         // Broadcast since its last dispatch
  logic               any_dispatch_q; // Something accepted since reset

  always_ff @(posedge clock) begin
    if (reset) begin
      sent_q         <= '0;
      any_dispatch_q <= 1'b0;
    end else if (en) begin
      if (cdb_valid) sent_q[cdb_tag] <= 1'b1;
      if (dispatch_fire) begin
        sent_q[dest_tag] <= 1'b0; // Tag reused, may broadcast again
        any_dispatch_q   <= 1'b1;
      end
    end
  end

  cdb_idle_after_reset: assert property (@(posedge clock) reset |=> !cdb_valid)
    else $error("CDB valid in the cycle after reset");

  cdb_tag_nonzero: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> cdb_tag != '0)
    else $error("Zero tag broadcast on the CDB");

  cdb_no_repeat: assert property (@(posedge clock) disable iff (reset)
    (en && cdb_valid) |-> !sent_q[cdb_tag])
    else $error("Tag %0d broadcast twice without a new dispatch", cdb_tag);

  ready_before_dispatch: assert property (@(posedge clock) disable iff (reset)
    !any_dispatch_q |-> dispatch_ready)
    else $error("dispatch_ready low before any dispatch");

endmodule

bind issue_core issue_core_asserts i_issue_core_asserts (
  .clock(clock), .reset(reset), .en(en),
  .dispatch_fire(dispatch_fire), .dest_tag(dest_tag),
  .dispatch_ready(dispatch_ready), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag)
);

// File: dv/issue_core_tb.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_core_tb;

  localparam int NUM_TAGS     = `NUM_TAGS;
  localparam int IND_COUNT    = 16;  // Independent dispatches
  localparam int CHAIN_COUNT  = 4;   // Directed chain
  localparam int DEP_COUNT    = 30;  // Random dependent dispatches
  localparam int HAZ_COUNT    = 3;
  localparam int MIX_COUNT    = 40;  // Mixed traffic with stalls
  localparam int NUM_DISPATCH = IND_COUNT + CHAIN_COUNT + DEP_COUNT + HAZ_COUNT + MIX_COUNT;
  localparam int WATCHDOG_CYCLES = NUM_DISPATCH * (`MUL_LAT + `NUM_FU + 4) + 100;
  localparam fu_pkg::fu_table_t FU_TABLE = `FU_LIST;

  logic          clock = 1'b0;
  logic          reset;
  logic          en;
  logic          dispatch_en;
  fu_pkg::fu_t   dispatch_fu;
  tag_pkg::tag_t dest_tag;
  tag_pkg::tag_t src1_tag;
  tag_pkg::tag_t src2_tag;
  logic          dispatch_ready;
  logic          cdb_valid;
  tag_pkg::tag_t cdb_tag;

  int seed       = 37123;
  int errors     = 0;
  int pass_count = 0;
  int fail_count = 0;
  int dispatched;                            // Accepted by the DUT
  int broadcast;                             // Seen on the CDB
  string test_name;                          // Test now running

  logic          tag_ready [NUM_TAGS];       // Value available
  logic          tag_busy  [NUM_TAGS];       // Dispatched, not yet on the CDB
  fu_pkg::fu_t   tag_class [NUM_TAGS];
  tag_pkg::tag_t tag_src   [NUM_TAGS][2];
  logic          tag_pend  [NUM_TAGS][2];    // Source still outstanding
  logic          prev_en;
  logic          prev_cdb_valid;
  tag_pkg::tag_t prev_cdb_tag;

  issue_core i_issue_core (
    .clock, .reset, .en,
    .dispatch_en, .dispatch_fu,
    .dest_tag, .src1_tag, .src2_tag,
    .dispatch_ready, .cdb_valid, .cdb_tag
  );

  always #20 clock = ~clock; // 40 ns period

  task automatic check_value(string name, int expected, int actual);
    if (expected != actual) begin
      $display("Fail %s %s: expected %0d, actual %0d at %0t", test_name, name, expected,
               actual, $time);
      errors++;
    end
  endtask

  // 1 must be high, 0 must be low, -1 when issue timing decides
  function automatic int expected_dispatch_ready(fu_pkg::fu_t cls, int in_flight, int waiting);
    int entries;
    entries = 0;
    for (int i = 0; i < `NUM_FU; i++) begin
      if (FU_TABLE[i] == cls) entries++; // Entries owned by the class
    end
    if (in_flight == 0) return 1;
    if (waiting >= entries) return 0;    // All parked on pending sources
    return -1;
  endfunction

  // Scoreboard update and checks on the pre-edge values
  always @(posedge clock) begin : compare
    int in_flight;
    int waiting;
    int expect_ready;
    if (reset) begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        tag_ready[t]   = 1'b1; // All tags ready out of reset
        tag_busy[t]    = 1'b0;
        tag_class[t]   = fu_pkg::FU_ALU;
        tag_src[t][0]  = '0;
        tag_src[t][1]  = '0;
        tag_pend[t][0] = 1'b0;
        tag_pend[t][1] = 1'b0;
      end
      dispatched     = 0;
      broadcast      = 0;
      prev_en        = 1'b1;
      prev_cdb_valid = 1'b0;
      prev_cdb_tag   = '0;
    end else begin
      if (!prev_en) begin // Frozen pipes hold the CDB
        check_value("cdb_valid_stall", int'(prev_cdb_valid), int'(cdb_valid));
        check_value("cdb_tag_stall", int'(prev_cdb_tag), int'(cdb_tag));
      end
      in_flight = 0;
      waiting   = 0;
      for (int t = 1; t < NUM_TAGS; t++) begin
        if (tag_busy[t] && tag_class[t] == dispatch_fu) begin
          in_flight++;
          if ((tag_pend[t][0] && !(cdb_valid && tag_src[t][0] == cdb_tag)) ||
              (tag_pend[t][1] && !(cdb_valid && tag_src[t][1] == cdb_tag))) begin
            waiting++; // Cannot issue this cycle
          end
        end
      end
      expect_ready = expected_dispatch_ready(dispatch_fu, in_flight, waiting);
      if (expect_ready >= 0) begin
        check_value("dispatch_ready", expect_ready, int'(dispatch_ready));
      end
      if (en && cdb_valid) begin
        check_value("cdb_tag_in_flight", 1, int'(tag_busy[cdb_tag]));
        check_value("cdb_sources_done", 0, int'(tag_pend[cdb_tag][0] | tag_pend[cdb_tag][1]));
        tag_busy[cdb_tag]  = 1'b0;
        tag_ready[cdb_tag] = 1'b1;
        broadcast++;
        for (int t = 1; t < NUM_TAGS; t++) begin
          for (int k = 0; k < 2; k++) begin
            if (tag_busy[t] && tag_src[t][k] == cdb_tag) tag_pend[t][k] = 1'b0; // Wakeup
          end
        end
      end
      if (en && dispatch_en && dispatch_ready) begin
        tag_pend[dest_tag][0] = !tag_ready[src1_tag]; // Sees this edge's CDB like the bypass
        tag_pend[dest_tag][1] = !tag_ready[src2_tag];
        tag_src[dest_tag][0]  = src1_tag;
        tag_src[dest_tag][1]  = src2_tag;
        tag_class[dest_tag]   = dispatch_fu;
        tag_busy[dest_tag]    = 1'b1;
        tag_ready[dest_tag]   = 1'b0;
        dispatched++;
      end
      prev_en        = en;
      prev_cdb_valid = cdb_valid;
      prev_cdb_tag   = cdb_tag;
    end
  end

  function automatic tag_pkg::tag_t free_tag();
    tag_pkg::tag_t t;
    do t = tag_pkg::tag_t'($random(seed)); while (t == '0 || tag_busy[t]);
    return t;
  endfunction

  function automatic tag_pkg::tag_t pick_source(bit any_src);
    tag_pkg::tag_t t;
    do t = tag_pkg::tag_t'($random(seed)); while (!any_src && !tag_ready[t]);
    return t;
  endfunction

  // Holds the instruction from a falling edge until taken
  task automatic send(fu_pkg::fu_t fu, tag_pkg::tag_t dst, tag_pkg::tag_t s1,
                      tag_pkg::tag_t s2, bit random_en);
    bit accepted;
    accepted = 1'b0;
    while (!accepted) begin
      en          = random_en ? (($random(seed) & 3) != 0) : 1'b1; // Quarter of cycles stalled
      dispatch_en = 1'b1;
      dispatch_fu = fu;
      dest_tag    = dst;
      src1_tag    = s1;
      src2_tag    = s2;
      @(posedge clock);
      accepted = en && dispatch_ready;
      @(negedge clock);
    end
  endtask

  task automatic send_random(bit any_src, bit random_en);
    fu_pkg::fu_t fu;
    fu = (($random(seed) & 1) != 0) ? fu_pkg::FU_MUL : fu_pkg::FU_ALU;
    send(fu, free_tag(), pick_source(any_src), pick_source(any_src), random_en);
  endtask

  task automatic drain();
    dispatch_en = 1'b0;
    en          = 1'b1;
    while (dispatched != broadcast) @(negedge clock);
    repeat (4) @(negedge clock); // Catch stray broadcasts
  endtask

  task automatic finish_test(int mark);
    if (errors == mark) begin
      pass_count++;
      $display("Test %s done: ok", test_name);
    end else begin
      fail_count++;
      $display("Test %s done: %0d errors", test_name, errors - mark);
    end
  endtask

  initial begin
    int mark;
    test_name   = "reset_state";
    reset       = 1'b1;
    en          = 1'b1;
    dispatch_en = 1'b0;
    dispatch_fu = fu_pkg::FU_ALU;
    dest_tag    = '0;
    src1_tag    = '0;
    src2_tag    = '0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    mark = errors; // Reset state
    dispatch_fu = fu_pkg::FU_ALU;
    @(posedge clock);
    check_value("reset_ready_alu", 1, int'(dispatch_ready));
    @(negedge clock);
    dispatch_fu = fu_pkg::FU_MUL;
    @(posedge clock);
    check_value("reset_ready_mul", 1, int'(dispatch_ready));
    repeat (5) begin
      @(posedge clock);
      check_value("reset_cdb_idle", 0, int'(cdb_valid));
    end
    @(negedge clock);
    finish_test(mark);

    test_name = "independent";
    mark = errors;
    repeat (IND_COUNT) send_random(1'b0, 1'b0); // Sources all ready
    drain();
    finish_test(mark);

    test_name = "dependency";
    mark = errors;
    send(fu_pkg::FU_MUL, 5'd20, '0, '0, 1'b0);     // Chain through both classes
    send(fu_pkg::FU_ALU, 5'd21, 5'd20, 5'd20, 1'b0);
    send(fu_pkg::FU_MUL, 5'd22, 5'd21, '0, 1'b0);
    send(fu_pkg::FU_ALU, 5'd23, 5'd22, 5'd21, 1'b0);
    repeat (DEP_COUNT) send_random(1'b1, 1'b0);
    drain();
    finish_test(mark);

    test_name = "hazard";
    mark = errors;
    send(fu_pkg::FU_MUL, 5'd10, '0, '0, 1'b0);
    send(fu_pkg::FU_ALU, 5'd11, 5'd10, '0, 1'b0);  // Both ALU entries wait on the MUL
    send(fu_pkg::FU_ALU, 5'd12, '0, 5'd10, 1'b0);
    dispatch_en = 1'b0;
    dispatch_fu = fu_pkg::FU_ALU;
    @(posedge clock);
    check_value("hazard_alu_blocked", 0, int'(dispatch_ready));
    @(negedge clock);
    dispatch_fu = fu_pkg::FU_MUL;
    @(posedge clock);
    check_value("hazard_mul_open", 1, int'(dispatch_ready));
    @(negedge clock);
    drain();
    finish_test(mark);

    test_name = "contention_stall";
    mark = errors;
    repeat (MIX_COUNT) send_random(1'b1, 1'b1);
    drain();
    finish_test(mark);

    $display("Tests passed %0d, failed %0d, check errors %0d", pass_count, fail_count, errors);
    if (fail_count == 0 && errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Timeout after %0d cycles, the DUT stopped completing tags", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: issue_core.f
+incdir+common
common/tag_pkg.sv
common/fu_pkg.sv
hw/ready_table.sv
hw/rs/rs.sv
hw/fu/fu_bank.sv
hw/cdb_arbiter.sv
hw/issue_core.sv
dv/issue_core_asserts.sv
dv/issue_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= issue_core_tb
FILELIST  ?= issue_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
